/* hdl/jtroc_dwnld_pkg.sv */
/*
    Shared types and widths for the ROM download path.
    Imported by the remapper, the write FIFO, the SDRAM writer,
    the PROM store and the download top level.
*/

package jtroc_dwnld_pkg;

    // SDRAM word address for 4M x 16
    localparam int SDRAM_AW = 22;

    // Loader byte address as sent by the ioctl interface
    localparam int IOCTL_AW = 25;

    // Colour PROM store of 1 kB
    localparam int PROM_AW = 10;

    // Region a downloaded byte belongs to
    typedef enum logic [2:0] {
        REG_MAIN = 3'd0,
        REG_SND  = 3'd1,
        REG_SCR  = 3'd2,
        REG_OBJ  = 3'd3,
        REG_PROM = 3'd4
    } region_t;

    // One SDRAM byte write
    // The byte sits in both halves of data and mask picks the half
    // Mask is active low
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [15:0]         data;
        logic [1:0]          mask;
    } wr_cmd_t;

    // One write into the colour PROM store
    typedef struct packed {
        logic [PROM_AW-1:0] addr;
        logic [7:0]         data;
        logic               we;
    } prom_wr_t;

endpackage

/* hdl/jtroc_dwnld_remap.sv */
/*
    Producer side of the ROM download.
    Sorts each loader byte by region, reorders the word address of
    the graphics regions and registers either an SDRAM byte write
    or a colour PROM write, one cycle after ioctl_wr.
*/

module jtroc_dwnld_remap #(
    parameter logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] SND_START  = 22'h0C000,
    parameter logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] SCR_START  = 22'h0E000,
    parameter logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] OBJ_START  = 22'h12000,
    parameter logic [jtroc_dwnld_pkg::IOCTL_AW-1:0] PROM_START = 25'h1A000,
    parameter bit                                   SWAB       = 1'b1
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [jtroc_dwnld_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                           ioctl_dout,
    input  logic                                 ioctl_wr,
    output jtroc_dwnld_pkg::wr_cmd_t             cmd,
    output logic                                 push,
    output jtroc_dwnld_pkg::prom_wr_t            prom_wr
);
    import jtroc_dwnld_pkg::*;

    region_t             region;
    logic [SDRAM_AW-1:0] word_addr;
    logic [SDRAM_AW-1:0] gfx_addr;
    logic [IOCTL_AW-1:0] prom_offset;
    logic [1:0]          byte_mask;
    logic                prom_we;
    logic [PROM_AW-1:0]  prom_addr;
    logic [7:0]          prom_data;

    // Region decode, highest region first
    always_comb begin
        if (ioctl_addr >= PROM_START) begin
            region = REG_PROM;
        end else if (ioctl_addr >= IOCTL_AW'(OBJ_START)) begin
            region = REG_OBJ;
        end else if (ioctl_addr >= IOCTL_AW'(SCR_START)) begin
            region = REG_SCR;
        end else if (ioctl_addr >= IOCTL_AW'(SND_START)) begin
            region = REG_SND;
        end else begin
            region = REG_MAIN;
        end
    end

    assign word_addr = ioctl_addr[SDRAM_AW:1];

    // Tile and sprite data are stored in the order the video fetches them
    always_comb begin
        gfx_addr = word_addr;
        case (region)
            REG_SCR: begin
                gfx_addr[0]   = ~word_addr[3];
                gfx_addr[3:1] = word_addr[2:0];
            end
            REG_OBJ: begin
                gfx_addr[0]   = ~word_addr[3];
                gfx_addr[1]   = ~word_addr[4];
                gfx_addr[5:2] = {word_addr[5], word_addr[2:0]};
            end
            default: gfx_addr = word_addr;
        endcase
    end

    // Even bytes go high when swapped, low otherwise
    assign byte_mask   = (ioctl_addr[0] ^ SWAB) ? 2'b01 : 2'b10;
    assign prom_offset = ioctl_addr - PROM_START;

    always_ff @(posedge clk) begin
        if (rst) begin
            push    <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            push    <= ioctl_wr && (region != REG_PROM);
            prom_we <= ioctl_wr && (region == REG_PROM);
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            cmd.addr  <= gfx_addr;
            cmd.data  <= {2{ioctl_dout}};
            cmd.mask  <= byte_mask;
            prom_addr <= prom_offset[PROM_AW-1:0];
            prom_data <= ioctl_dout;
        end
    end

    assign prom_wr = '{addr: prom_addr, data: prom_data, we: prom_we};

endmodule

/* hdl/jtroc_wr_fifo.sv */
/*
    Circular buffer of pending SDRAM write commands.
    An empty buffer shows an incoming command at its head in the same
    cycle. Pushes into a full buffer are lost and set a sticky overflow.
*/

module jtroc_wr_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  jtroc_dwnld_pkg::wr_cmd_t din,
    input  logic                     pop,
    output jtroc_dwnld_pkg::wr_cmd_t dout,
    output logic                     not_empty,
    output logic                     overflow
);
    import jtroc_dwnld_pkg::*;

    // Depth must be a power of two, at least 2
    localparam int PW = $clog2(FIFO_DEPTH);

    wr_cmd_t       mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          full;
    logic          empty;
    logic          do_push;
    logic          do_pop;

    assign empty   = count == '0;
    assign full    = count == (PW+1)'(FIFO_DEPTH);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PW+1)'(do_push) - (PW+1)'(do_pop);
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // Head entry, bypassed from the input while empty
    assign not_empty = !empty || push;
    assign dout      = empty ? din : mem[rd_ptr];

endmodule

/* hdl/jtroc_sdram_wr.sv */
/*
    SDRAM write port of the download path.
    Takes the FIFO head, raises sdram_req with address, data and mask,
    holds all of them until sdram_ack, then pops the FIFO. The request
    stays low for at least one cycle between writes.
*/

module jtroc_sdram_wr (
    input  logic                                 clk,
    input  logic                                 rst,
    input  jtroc_dwnld_pkg::wr_cmd_t             cmd,
    input  logic                                 not_empty,
    input  logic                                 sdram_ack,
    output logic                                 pop,
    output logic                                 sdram_req,
    output logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic [15:0]                          sdram_din,
    output logic [1:0]                           sdram_mask
);

    logic start;
    logic done;

    // Two states: idle (req low) and waiting for ack (req high)
    assign start = !sdram_req && not_empty;
    assign done  = sdram_req && sdram_ack;

    // The head leaves the FIFO only once the SDRAM took it
    assign pop = done;

    always_ff @(posedge clk) begin
        if (rst) begin
            sdram_req <= 1'b0;
        end else if (start) begin
            sdram_req <= 1'b1;
        end else if (done) begin
            sdram_req <= 1'b0;
        end
    end

    // Loaded only when idle, so the bus holds still while waiting
    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= cmd.addr;
            sdram_din  <= cmd.data;
            sdram_mask <= cmd.mask;
        end
    end

endmodule

/* hdl/jtroc_prom.sv */
/*
    Colour PROM store, 1 kB.
    Filled by the remapper during download, read by the video side
    with one cycle of latency.
*/

module jtroc_prom (
    input  logic                                clk,
    input  jtroc_dwnld_pkg::prom_wr_t           prom_wr,
    input  logic [jtroc_dwnld_pkg::PROM_AW-1:0] prom_addr,
    output logic [7:0]                          prom_data
);
    import jtroc_dwnld_pkg::*;

    logic [7:0] mem [2**PROM_AW];

    always_ff @(posedge clk) begin
        if (prom_wr.we) begin
            mem[prom_wr.addr] <= prom_wr.data;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        prom_data <= mem[prom_addr];
    end

endmodule

/* hdl/jtroc_dwnld.sv */
/*
    Top level of the ROM download path.
    Loader bytes go through the remapper, then either to the colour
    PROM store or through the write FIFO to the SDRAM writer.
    Region offsets, byte swap and FIFO depth are set here.
*/

module jtroc_dwnld #(
    parameter logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] SND_START  = 22'h0C000,
    parameter logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] SCR_START  = 22'h0E000,
    parameter logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] OBJ_START  = 22'h12000,
    parameter logic [jtroc_dwnld_pkg::IOCTL_AW-1:0] PROM_START = 25'h1A000,
    parameter bit                                   SWAB       = 1'b1,
    parameter int                                   FIFO_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 downloading,
    input  logic [jtroc_dwnld_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                           ioctl_dout,
    input  logic                                 ioctl_wr,
    input  logic                                 sdram_ack,
    input  logic [jtroc_dwnld_pkg::PROM_AW-1:0]  prom_addr,
    output logic                                 sdram_req,
    output logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic [15:0]                          sdram_din,
    output logic [1:0]                           sdram_mask,
    output logic [7:0]                           prom_data,
    output logic                                 dwnld_busy,
    output logic                                 overflow
);
    import jtroc_dwnld_pkg::*;

    wr_cmd_t  cmd;
    wr_cmd_t  head;
    prom_wr_t prom_wr;
    logic     push;
    logic     pop;
    logic     not_empty;

    // Busy until every queued write has reached the SDRAM
    assign dwnld_busy = downloading || not_empty || sdram_req;

    jtroc_dwnld_remap #(
        .SND_START  ( SND_START  ),
        .SCR_START  ( SCR_START  ),
        .OBJ_START  ( OBJ_START  ),
        .PROM_START ( PROM_START ),
        .SWAB       ( SWAB       )
    ) u_remap (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .ioctl_wr   ( ioctl_wr   ),
        .cmd        ( cmd        ),
        .push       ( push       ),
        .prom_wr    ( prom_wr    )
    );

    jtroc_wr_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_fifo (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .push       ( push       ),
        .din        ( cmd        ),
        .pop        ( pop        ),
        .dout       ( head       ),
        .not_empty  ( not_empty  ),
        .overflow   ( overflow   )
    );

    jtroc_sdram_wr u_wr (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cmd        ( head       ),
        .not_empty  ( not_empty  ),
        .sdram_ack  ( sdram_ack  ),
        .pop        ( pop        ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_din  ( sdram_din  ),
        .sdram_mask ( sdram_mask )
    );

    jtroc_prom u_prom (
        .clk        ( clk        ),
        .prom_wr    ( prom_wr    ),
        .prom_addr  ( prom_addr  ),
        .prom_data  ( prom_data  )
    );

endmodule

/* tests/jtroc_dwnld_sva.sv */
/*
    Concurrent checks on the SDRAM handshake and the remapper outputs.
    Bound into every instance of jtroc_dwnld.
*/

module jtroc_dwnld_sva (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 sdram_req,
    input logic                                 sdram_ack,
    input logic [jtroc_dwnld_pkg::SDRAM_AW-1:0] sdram_addr,
    input logic [15:0]                          sdram_din,
    input logic [1:0]                           sdram_mask,
    input logic                                 push,
    input logic                                 prom_we
);
    timeunit 1ns;
    timeprecision 1ps;

    // Request and its bus hold still until the SDRAM answers
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr)
            && $stable(sdram_din) && $stable(sdram_mask))
        else $error("SDRAM request or its bus changed before sdram_ack");

    // One idle cycle after each acknowledge
    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        sdram_req && sdram_ack |=> !sdram_req)
        else $error("sdram_req still high after sdram_ack");

    // A byte goes either to the FIFO or to the PROM store
    a_one_sink: assert property (@(posedge clk) disable iff (rst)
        !(push && prom_we))
        else $error("push and PROM write enable high together");

endmodule

bind jtroc_dwnld jtroc_dwnld_sva u_sva (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .sdram_req  ( sdram_req  ),
    .sdram_ack  ( sdram_ack  ),
    .sdram_addr ( sdram_addr ),
    .sdram_din  ( sdram_din  ),
    .sdram_mask ( sdram_mask ),
    .push       ( push       ),
    .prom_we    ( prom_wr.we )
);

/* tests/jtroc_dwnld_tb.sv */
/*
    Testbench for the ROM download path.
    Sends main, sound, graphics and PROM bytes into jtroc_dwnld, answers
    SDRAM requests from a memory model with random latency, and checks
    requests, SDRAM contents, PROM reads, busy and overflow.
*/

module jtroc_dwnld_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import jtroc_dwnld_pkg::*;

    localparam logic [SDRAM_AW-1:0] SND_START  = 22'h0C000;
    localparam logic [SDRAM_AW-1:0] SCR_START  = 22'h0E000;
    localparam logic [SDRAM_AW-1:0] OBJ_START  = 22'h12000;
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h1A000;
    localparam bit                  SWAB       = 1'b1;
    localparam int                  FIFO_DEPTH = 8;

    // Expected outcome of one loader byte
    typedef struct packed {
        logic               is_prom;
        logic [PROM_AW-1:0] prom_addr;
        wr_cmd_t            cmd;
    } expect_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                downloading;
    logic [IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                ioctl_wr;
    logic                sdram_ack = 1'b0;
    logic [PROM_AW-1:0]  prom_addr;
    logic                sdram_req;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic [15:0]         sdram_din;
    logic [1:0]          sdram_mask;
    logic [7:0]          prom_data;
    logic                dwnld_busy;
    logic                overflow;

    integer      seed = 32'h96e80d9d;
    wr_cmd_t     exp_q [$];
    logic [15:0] exp_mem [logic [SDRAM_AW-1:0]];
    logic [15:0] sdram_mem [logic [SDRAM_AW-1:0]];
    logic [7:0]  prom_exp [logic [PROM_AW-1:0]];
    wr_cmd_t     seen_exp;
    int unsigned ack_delay;
    logic        model_busy = 1'b0;
    logic        ack_hold;
    logic        abort;
    int          errors;
    int          cmp_errors = 0;
    int          checks = 0;

    always #50 clk = ~clk;

    jtroc_dwnld #(
        .SND_START  ( SND_START  ),
        .SCR_START  ( SCR_START  ),
        .OBJ_START  ( OBJ_START  ),
        .PROM_START ( PROM_START ),
        .SWAB       ( SWAB       ),
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) UUT (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prom_addr   ( prom_addr   ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_din   ( sdram_din   ),
        .sdram_mask  ( sdram_mask  ),
        .prom_data   ( prom_data   ),
        .dwnld_busy  ( dwnld_busy  ),
        .overflow    ( overflow    )
    );

    // Expected SDRAM write or PROM write for one loader byte
    function automatic expect_t ref_map(input logic [IOCTL_AW-1:0] a, input logic [7:0] d);
        expect_t             e;
        logic [SDRAM_AW-1:0] w;
        logic [SDRAM_AW-1:0] n;
        logic [IOCTL_AW-1:0] off;
        e   = '0;
        w   = SDRAM_AW'(a >> 1);
        n   = w;
        off = a - PROM_START;
        if (a >= PROM_START) begin
            e.is_prom   = 1'b1;
            e.prom_addr = off[PROM_AW-1:0];
        end else begin
            if (a >= IOCTL_AW'(OBJ_START)) begin
                n[0]   = ~w[3];
                n[1]   = ~w[4];
                n[5:2] = {w[5], w[2:0]};
            end else if (a >= IOCTL_AW'(SCR_START)) begin
                n[0]   = ~w[3];
                n[3:1] = w[2:0];
            end
            e.cmd.addr = n;
            e.cmd.data = {d, d};
            // Even byte to the upper half when swapped
            if (SWAB) begin
                e.cmd.mask = a[0] ? 2'b10 : 2'b01;
            end else begin
                e.cmd.mask = a[0] ? 2'b01 : 2'b10;
            end
        end
        return e;
    endfunction

    // Active low mask, bit 1 guards the upper byte
    function automatic logic [15:0] merge_byte(input logic [15:0] old, input logic [15:0] din,
                                               input logic [1:0] mask);
        logic [15:0] w;
        w = old;
        if (!mask[1]) begin
            w[15:8] = din[15:8];
        end
        if (!mask[0]) begin
            w[7:0] = din[7:0];
        end
        return w;
    endfunction

    // SDRAM model, one acknowledge per request after 0 to 5 cycles
    always @(posedge clk) begin
        #1;
        if (rst || sdram_ack) begin
            sdram_ack  = 1'b0;
            model_busy = 1'b0;
        end else begin
            if (sdram_req && !model_busy) begin
                model_busy = 1'b1;
                ack_delay  = $unsigned($random(seed)) % 6;
            end
            if (model_busy && !ack_hold) begin
                if (ack_delay == 0) begin
                    sdram_ack = 1'b1;
                    if (!sdram_mem.exists(sdram_addr)) begin
                        sdram_mem[sdram_addr] = 16'h0000;
                    end
                    sdram_mem[sdram_addr] = merge_byte(sdram_mem[sdram_addr], sdram_din,
                                                       sdram_mask);
                end else begin
                    ack_delay = ack_delay - 1;
                end
            end
        end
    end

    // Each accepted request against the next expected write
    always @(negedge clk) begin
        if (!rst && sdram_req && sdram_ack) begin
            checks = checks + 1;
            assert (exp_q.size() > 0) else begin
                cmp_errors = cmp_errors + 1;
                $display("SDRAM request at word %h while no write was expected", sdram_addr);
            end
            if (exp_q.size() > 0) begin
                seen_exp = exp_q.pop_front();
                assert (sdram_addr == seen_exp.addr) else begin
                    cmp_errors = cmp_errors + 1;
                    $display("CHECK FAILED sdram_addr expected %h observed %h",
                             seen_exp.addr, sdram_addr);
                end
                assert (sdram_din == seen_exp.data) else begin
                    cmp_errors = cmp_errors + 1;
                    $display("CHECK FAILED sdram_din expected %h observed %h",
                             seen_exp.data, sdram_din);
                end
                assert (sdram_mask == seen_exp.mask) else begin
                    cmp_errors = cmp_errors + 1;
                    $display("CHECK FAILED sdram_mask expected %h observed %h",
                             seen_exp.mask, sdram_mask);
                end
            end
        end
    end

    // Next rising edge plus the drive delay
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        errors = errors + 1;
        $display("Timeout while waiting for %s", what);
        abort = 1'b1;
        forever @(posedge clk);
    endtask

    // Gap of 1 keeps ioctl_wr high into the next byte
    task automatic send_byte(input logic [IOCTL_AW-1:0] a, input int gap, input bit keep);
        expect_t    e;
        logic [7:0] d;
        d = 8'(a ^ (a >> 8)) ^ 8'h5a;
        e = ref_map(a, d);
        if (e.is_prom) begin
            prom_exp[e.prom_addr] = d;
        end else if (keep) begin
            exp_q.push_back(e.cmd);
            if (!exp_mem.exists(e.cmd.addr)) begin
                exp_mem[e.cmd.addr] = 16'h0000;
            end
            exp_mem[e.cmd.addr] = merge_byte(exp_mem[e.cmd.addr], e.cmd.data, e.cmd.mask);
        end
        tick();
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        if (gap > 1) begin
            tick();
            ioctl_wr = 1'b0;
            repeat (gap - 2) tick();
        end
    endtask

    task automatic send_region(input logic [IOCTL_AW-1:0] base, input int count, input int step);
        int i;
        for (i = 0; i < count; i++) begin
            send_byte(base + IOCTL_AW'(i * step), 8, 1'b1);
        end
    endtask

    // Busy must hold while any write is still on its way
    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n = n + 1;
            assert (dwnld_busy || exp_q.size() == 0) else begin
                errors = errors + 1;
                $display("dwnld_busy low with %0d writes still pending", exp_q.size());
            end
        end while (dwnld_busy && n < limit);
        if (dwnld_busy) begin
            abort_run("dwnld_busy to fall");
        end
    endtask

    task automatic wait_overflow(input int limit);
        int n;
        n = 0;
        while (!overflow && n < limit) begin
            @(negedge clk);
            n = n + 1;
        end
        if (!overflow) begin
            abort_run("overflow to be set");
        end
    endtask

    task automatic check_sdram_mem();
        foreach (exp_mem[k]) begin
            assert (sdram_mem.exists(k)) else begin
                errors = errors + 1;
                $display("SDRAM word %h was never written", k);
            end
            if (sdram_mem.exists(k)) begin
                assert (sdram_mem[k] == exp_mem[k]) else begin
                    errors = errors + 1;
                    $display("CHECK FAILED sdram_mem[%h] expected %h observed %h",
                             k, exp_mem[k], sdram_mem[k]);
                end
            end
        end
    endtask

    // One cycle of read latency
    task automatic check_prom();
        foreach (prom_exp[k]) begin
            tick();
            prom_addr = k;
            @(posedge clk);
            @(negedge clk);
            assert (prom_data == prom_exp[k]) else begin
                errors = errors + 1;
                $display("CHECK FAILED prom_data at %h expected %h observed %h",
                         k, prom_exp[k], prom_data);
            end
        end
    endtask

    task automatic run_tests();
        int i;
        tick();
        downloading = 1'b1;
        send_region(25'h00100, 4, 1);
        send_region(IOCTL_AW'(SND_START) + 25'h10, 4, 1);
        send_region(IOCTL_AW'(SCR_START) + 25'h20, 12, 5);
        send_region(IOCTL_AW'(OBJ_START) + 25'h40, 12, 7);
        send_region(PROM_START + 25'h8, 10, 3);
        tick();
        downloading = 1'b0;
        wait_idle(100);
        assert (overflow == 1'b0) else begin
            errors = errors + 1;
            $display("CHECK FAILED overflow expected %h observed %h", 1'b0, overflow);
        end
        assert (exp_q.size() == 0) else begin
            errors = errors + 1;
            $display("%0d expected writes never reached the SDRAM", exp_q.size());
        end
        check_sdram_mem();
        check_prom();

        // Stalled SDRAM, one byte more than the FIFO holds
        tick();
        ack_hold    = 1'b1;
        downloading = 1'b1;
        for (i = 0; i <= FIFO_DEPTH; i++) begin
            send_byte(25'h00400 + IOCTL_AW'(i), 1, i < FIFO_DEPTH);
        end
        tick();
        ioctl_wr = 1'b0;
        wait_overflow(20);
        tick();
        downloading = 1'b0;
        ack_hold    = 1'b0;
        wait_idle(200);
        assert (exp_q.size() == 0) else begin
            errors = errors + 1;
            $display("%0d stalled writes never reached the SDRAM", exp_q.size());
        end
        assert (overflow == 1'b1) else begin
            errors = errors + 1;
            $display("CHECK FAILED overflow expected %h observed %h", 1'b1, overflow);
        end
    endtask

    initial begin
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        prom_addr   = '0;
        ack_hold    = 1'b0;
        abort       = 1'b0;
        errors      = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            run_tests();
            wait (abort);
        join_any
        $display("Done: %0d SDRAM writes compared, %0d errors", checks, errors + cmp_errors);
        if (errors + cmp_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/jtroc_dwnld_pkg.sv
hdl/jtroc_dwnld_remap.sv
hdl/jtroc_wr_fifo.sv
hdl/jtroc_sdram_wr.sv
hdl/jtroc_prom.sv
hdl/jtroc_dwnld.sv
tests/jtroc_dwnld_sva.sv
tests/jtroc_dwnld_tb.sv

/* Makefile */
# Verilator build and run of the ROM download testbench

VERILATOR ?= verilator
TOP       ?= jtroc_dwnld_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
